// ==== common/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Instruction field selects, applied directly after the word.
`define FIELD_COND   [31:28]
`define FIELD_OPCODE [24:21]
`define FIELD_RN     [19:16]
`define FIELD_RD     [15:12]
`define FIELD_RS     [11:8]
`define FIELD_RM     [3:0]
`define FIELD_LIST   [15:0]
`define FIELD_OFF12  [11:0]
`define FIELD_OFF24  [23:0]

`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_CS 4'b0010
`define COND_CC 4'b0011
`define COND_MI 4'b0100
`define COND_PL 4'b0101
`define COND_VS 4'b0110
`define COND_VC 4'b0111
`define COND_HI 4'b1000
`define COND_LS 4'b1001
`define COND_GE 4'b1010
`define COND_LT 4'b1011
`define COND_GT 4'b1100
`define COND_LE 4'b1101
`define COND_AL 4'b1110
`define COND_NV 4'b1111

`endif

// ==== common/core_pkg.sv ====
package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list;
	typedef logic [3:0]  alu_op;
	typedef logic [3:0]  list_index; // Position of a register within a multiple transfer.

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef struct packed {
		logic       is_imm;
		logic       shift_by_reg;
		logic [1:0] shift;
		logic [4:0] shift_imm;
		reg_num     rs;
		reg_num     rm;
		logic [7:0] imm8;
		logic [3:0] rotate; // The immediate rotates right by twice this value.
	} shifter_op;

	typedef struct packed {
		alu_op     op;
		reg_num    rn;
		reg_num    rd;
		logic      writeback;
		logic      update_flags;
		shifter_op snd;
	} data_decode;

	typedef struct packed {
		logic        load;
		logic        pre_index;
		logic        increment;
		logic        writeback_base;
		logic        multiple;
		logic        byte_xfer;
		reg_num      rn;
		reg_num      rd;
		reg_list     regs;
		logic [11:0] off_imm;
	} ldst_decode;

	typedef struct packed {
		logic        link;
		logic [23:0] offset; // Word offset, sign extended by execute.
	} branch_decode;

	typedef struct packed {
		logic execute;
		logic undefined;
		logic conditional;
		logic branch;
		logic ldst;
		logic data;
	} ctrl_decode;

	typedef struct packed {
		ctrl_decode   ctrl;
		data_decode   data;
		ldst_decode   ldst;
		branch_decode branch;
	} insn_decode;

	typedef struct packed {
		insn_decode dec;
		reg_num     xfer_reg;
		list_index  xfer_index;
		logic       first;
		logic       last;
	} micro_op;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		MULTI
	} issue_state;

endpackage

// ==== core/decode/core_decode.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core_decode
	import core_pkg::*;
(
	input  word        insn,
	input  psr_flags   flags,

	output insn_decode dec
);

	logic cond_execute, cond_undefined, cond_conditional;

	core_decode_conds conds
	(
		.cond(insn `FIELD_COND),
		.flags(flags),
		.execute(cond_execute),
		.undefined(cond_undefined),
		.conditional(cond_conditional)
	);

	data_decode data;
	logic data_undefined;

	core_decode_data group_data
	(
		.insn(insn),
		.decode(data),
		.undefined(data_undefined)
	);

	ldst_decode ldst;
	branch_decode branch;
	logic is_ldst, is_branch, ldst_undefined;

	core_decode_ldst group_ldst
	(
		.insn(insn),
		.ldst(ldst),
		.branch(branch),
		.is_ldst(is_ldst),
		.is_branch(is_branch),
		.undefined(ldst_undefined)
	);

	logic is_data, claimed, group_undefined, undefined;

	assign is_data = insn[27:26] == 2'b00;
	assign claimed = is_data || is_ldst || is_branch; // Coprocessor space falls through.

	always_comb begin
		group_undefined = 1'b0;
		if (is_data)
			group_undefined = data_undefined;
		else if (is_ldst || is_branch)
			group_undefined = ldst_undefined;
	end

	assign undefined = cond_undefined || !claimed || group_undefined;

	// An undefined word never executes, whatever its condition.
	assign dec.ctrl.execute = cond_execute && !undefined;
	assign dec.ctrl.undefined = undefined;
	assign dec.ctrl.conditional = cond_conditional;
	assign dec.ctrl.branch = is_branch;
	assign dec.ctrl.ldst = is_ldst;
	assign dec.ctrl.data = is_data;

	assign dec.data = is_data ? data : '0;
	assign dec.ldst = is_ldst ? ldst : '0;
	assign dec.branch = is_branch ? branch : '0;

endmodule

// ==== core/decode/core_decode_conds.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core_decode_conds
	import core_pkg::*;
(
	input  logic [3:0] cond,
	input  psr_flags   flags,

	output logic       execute,
	output logic       undefined,
	output logic       conditional
);

	always_comb begin
		execute = 1'b0;
		undefined = 1'b0;
		conditional = 1'b1;

		case (cond)
			`COND_EQ: execute = flags.z;
			`COND_NE: execute = !flags.z;
			`COND_CS: execute = flags.c;
			`COND_CC: execute = !flags.c;
			`COND_MI: execute = flags.n;
			`COND_PL: execute = !flags.n;
			`COND_VS: execute = flags.v;
			`COND_VC: execute = !flags.v;
			`COND_HI: execute = flags.c && !flags.z;
			`COND_LS: execute = !flags.c || flags.z;
			`COND_GE: execute = flags.n == flags.v;
			`COND_LT: execute = flags.n != flags.v;
			`COND_GT: execute = !flags.z && (flags.n == flags.v);
			`COND_LE: execute = flags.z || (flags.n != flags.v);
			`COND_AL: begin
				execute = 1'b1;
				conditional = 1'b0;
			end
			`COND_NV: begin
				undefined = 1'b1; // Reserved on this architecture.
				conditional = 1'b0;
			end
		endcase
	end

endmodule

// ==== core/decode/core_decode_data.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core_decode_data
	import core_pkg::*;
(
	input  word        insn,

	output data_decode decode,
	output logic       undefined
);

	alu_op op;
	logic is_test, set_flags, is_imm, mul_space;

	assign op = insn `FIELD_OPCODE;
	assign set_flags = insn[20];
	assign is_imm = insn[25];

	// TST, TEQ, CMP and CMN only touch the flags.
	assign is_test = op[3:2] == 2'b10;

	// Bits 7 and 4 both set select multiply, swap and halfword encodings.
	assign mul_space = !is_imm && insn[7] && insn[4];

	assign decode.op = op;
	assign decode.rn = insn `FIELD_RN;
	assign decode.rd = insn `FIELD_RD;
	assign decode.writeback = !is_test;
	assign decode.update_flags = set_flags;

	assign decode.snd.is_imm = is_imm;
	assign decode.snd.shift_by_reg = !is_imm && insn[4];
	assign decode.snd.shift = insn[6:5];
	assign decode.snd.shift_imm = insn[11:7];
	assign decode.snd.rs = insn `FIELD_RS;
	assign decode.snd.rm = insn `FIELD_RM;
	assign decode.snd.imm8 = insn[7:0];
	assign decode.snd.rotate = insn[11:8];

	// A test without S is where MRS and MSR live.
	assign undefined = (is_test && !set_flags) || mul_space;

endmodule

// ==== core/decode/core_decode_ldst.sv ====
`timescale 1ns/1ps
`include "core_macros.svh"

module core_decode_ldst
	import core_pkg::*;
(
	input  word          insn,

	output ldst_decode   ldst,
	output branch_decode branch,
	output logic         is_ldst,
	output logic         is_branch,
	output logic         undefined
);

	logic single, multiple, reg_offset;
	reg_list regs;

	assign single = insn[27:26] == 2'b01;
	assign multiple = insn[27:25] == 3'b100;
	assign reg_offset = single && insn[25];
	assign regs = insn `FIELD_LIST;

	assign is_ldst = single || multiple;
	assign is_branch = insn[27:25] == 3'b101;

	assign ldst.load = insn[20];
	assign ldst.pre_index = insn[24];
	assign ldst.increment = insn[23];
	assign ldst.multiple = multiple;
	assign ldst.byte_xfer = single && insn[22];
	assign ldst.rn = insn `FIELD_RN;

	// Post-indexed single transfers always update the base.
	assign ldst.writeback_base = multiple ? insn[21] : (!insn[24] || insn[21]);

	always_comb begin
		ldst.rd = insn `FIELD_RD;
		ldst.regs = '0;
		ldst.off_imm = insn `FIELD_OFF12;
		if (multiple) begin
			ldst.rd = '0;
			ldst.regs = regs;
			ldst.off_imm = '0;
		end
	end

	assign branch.link = insn[24];
	assign branch.offset = insn `FIELD_OFF24;

	assign undefined = (multiple && regs == '0) || reg_offset;

endmodule

// ==== project.f ====
+incdir+common
common/core_pkg.sv
core/decode/core_decode_conds.sv
core/decode/core_decode_data.sv
core/decode/core_decode_ldst.sv
core/decode/core_decode.sv
src/core_reglist_counter.sv
src/core_issue_seq.sv
src/core_decode_stage.sv
sim/core_decode_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project root"
	exit 1
fi

verilator --binary --timing -f project.f --top-module core_decode_tb -o core_decode_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_decode_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
exit 0

// ==== sim/core_decode_tb.sv ====
`timescale 1ns/1ps

module core_decode_tb
	import core_pkg::*;
();

	localparam int COLS = 14; // Words per vector record.
	localparam int MAX_RECORDS = 48;
	localparam int TIMEOUT = 100;
	localparam logic [31:0] END_MARK = 32'hffff_ffff;

	logic clk = 1'b0;
	logic reset;
	word insn;
	psr_flags flags;
	logic insn_valid, insn_ready;
	micro_op uop;
	logic uop_valid;
	logic uop_ready = 1'b1;

	logic [31:0] vectors [0:COLS*MAX_RECORDS-1];
	logic random_ready, aborted;
	int errors, checks, tests, test_errors, num_records;

	core_decode_stage uut
	(
		.clk(clk),
		.reset(reset),
		.insn(insn),
		.flags(flags),
		.insn_valid(insn_valid),
		.insn_ready(insn_ready),
		.uop(uop),
		.uop_valid(uop_valid),
		.uop_ready(uop_ready)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		uop_ready <= random_ready ? 1'($urandom) : 1'b1;

	task automatic check(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("MISMATCH %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		errors++;
		test_errors++;
		aborted = 1'b1;
	endtask

	task automatic send_insn(input word w, input psr_flags f);
		int waited;
		waited = 0;
		@(posedge clk);
		insn <= w;
		flags <= f;
		insn_valid <= 1'b1;
		@(negedge clk);
		while (!insn_ready) begin
			if (waited == TIMEOUT) begin
				report_timeout("the stage to accept an instruction");
				return;
			end
			waited++;
			@(negedge clk);
		end
		@(posedge clk); // The word is taken on this edge.
		insn_valid <= 1'b0;
	endtask

	task automatic compare_decode(input int base);
		check("ctrl.execute", 128'(uop.dec.ctrl.execute), 128'(vectors[base + 2]));
		check("ctrl.undefined", 128'(uop.dec.ctrl.undefined), 128'(vectors[base + 3]));
		check("ctrl.branch", 128'(uop.dec.ctrl.branch), 128'(vectors[base + 4]));
		check("ctrl.ldst", 128'(uop.dec.ctrl.ldst), 128'(vectors[base + 5]));
		check("ctrl.data", 128'(uop.dec.ctrl.data), 128'(vectors[base + 6]));
		if (vectors[base + 6] != 0)
			check("data.rd", 128'(uop.dec.data.rd), 128'(vectors[base + 7]));
		else
			check("ldst.rd", 128'(uop.dec.ldst.rd), 128'(vectors[base + 7]));
		check("data.op", 128'(uop.dec.data.op), 128'(vectors[base + 8]));
		check("data.writeback", 128'(uop.dec.data.writeback), 128'(vectors[base + 9]));
		check("data.snd kind", 128'({uop.dec.data.snd.is_imm, uop.dec.data.snd.shift_by_reg}),
			128'(vectors[base + 10]));
		check("branch.link", 128'(uop.dec.branch.link), 128'(vectors[base + 11]));
		check("branch.offset", 128'(uop.dec.branch.offset), 128'(vectors[base + 12]));
		check("ldst.regs", 128'(uop.dec.ldst.regs), 128'(vectors[base + 13]));
	endtask

	task automatic receive_uop(input int base, input int idx, input reg_num exp_reg,
			input logic exp_last);
		int waited;
		logic stalled;
		micro_op held;
		waited = 0;
		stalled = 1'b0;
		held = '0;
		@(negedge clk);
		forever begin
			// A stalled micro-op must not move or drop out.
			if (stalled) begin
				check("uop_valid", 128'(uop_valid), 128'(1'b1));
				check("uop", 128'(uop), 128'(held));
			end
			if (uop_valid && uop_ready)
				break;
			if (waited == TIMEOUT) begin
				report_timeout("a micro-op");
				return;
			end
			stalled = uop_valid;
			held = uop;
			waited++;
			@(negedge clk);
		end
		compare_decode(base);
		check("xfer_reg", 128'(uop.xfer_reg), 128'(exp_reg));
		check("xfer_index", 128'(uop.xfer_index), 128'(idx));
		check("first", 128'(uop.first), 128'(idx == 0));
		check("last", 128'(uop.last), 128'(exp_last));
		// The stage takes a new word only as the last micro-op leaves.
		check("insn_ready", 128'(insn_ready), 128'(exp_last));
	endtask

	task automatic run_record(input int r, input int round);
		int base, count;
		reg_list regs;
		reg_num single_reg;
		base = r * COLS;
		regs = vectors[base + 13][15:0];
		count = 0;
		test_errors = 0;
		tests++;
		send_insn(vectors[base], psr_flags'(vectors[base + 1][3:0]));
		if (vectors[base + 2][0] && regs != '0) begin
			// One micro-op per listed register, lowest first.
			for (int b = 0; b < 16; b++) begin
				if (regs[b] && !aborted) begin
					receive_uop(base, count, reg_num'(b), (regs >> (b + 1)) == '0);
					count++;
				end
			end
		end else if (!aborted) begin
			single_reg = (vectors[base + 5][0] && regs == '0) ? vectors[base + 7][3:0] : '0;
			receive_uop(base, 0, single_reg, 1'b1);
			count = 1;
		end
		if (!aborted) begin
			@(negedge clk);
			check("uop_valid after last", 128'(uop_valid), 128'(1'b0));
			check("insn_ready after last", 128'(insn_ready), 128'(1'b1));
		end
		$display("round %0d test %0d insn %08h: %0d micro-ops, %s", round, r,
			vectors[base], count, test_errors == 0 ? "ok" : "failed");
	endtask

	initial begin
		reset = 1'b1;
		insn = '0;
		flags = '0;
		insn_valid = 1'b0;
		random_ready = 1'b0;
		aborted = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(32'hd18f_5f97));
		$readmemh("sim/decode_input_vectors.txt", vectors);
		num_records = 0;
		while (num_records < MAX_RECORDS && vectors[num_records * COLS] != END_MARK)
			num_records++;
		if (num_records == 0 || num_records == MAX_RECORDS) begin
			$display("The vector file holds no records or lacks its end marker");
			errors++;
			aborted = 1'b1;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// Round 0 runs with uop_ready high, round 1 with random back-pressure.
		for (int round = 0; round < 2 && !aborted; round++) begin
			random_ready = round == 1;
			for (int r = 0; r < num_records && !aborted; r++)
				run_record(r, round);
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== sim/decode_input_vectors.txt ====
// insn flags(NZCV) execute undefined branch ldst data rd opcode writeback
// kind(0 shift by imm, 1 shift by reg, 2 imm) link offset24 list; FFFFFFFF ends the list
03A01012 4 1 0 0 0 1 1 D 1 2 0 000000 0000
13A01012 4 0 0 0 0 1 1 D 1 2 0 000000 0000
23A01012 2 1 0 0 0 1 1 D 1 2 0 000000 0000
33A01012 2 0 0 0 0 1 1 D 1 2 0 000000 0000
43A01012 8 1 0 0 0 1 1 D 1 2 0 000000 0000
53A01012 8 0 0 0 0 1 1 D 1 2 0 000000 0000
63A01012 1 1 0 0 0 1 1 D 1 2 0 000000 0000
73A01012 0 1 0 0 0 1 1 D 1 2 0 000000 0000
83A01012 2 1 0 0 0 1 1 D 1 2 0 000000 0000
93A01012 2 0 0 0 0 1 1 D 1 2 0 000000 0000
A3A01012 9 1 0 0 0 1 1 D 1 2 0 000000 0000
B3A01012 8 1 0 0 0 1 1 D 1 2 0 000000 0000
C3A01012 4 0 0 0 0 1 1 D 1 2 0 000000 0000
D3A01012 1 1 0 0 0 1 1 D 1 2 0 000000 0000
E3A01012 0 1 0 0 0 1 1 D 1 2 0 000000 0000
F3A01012 F 0 1 0 0 1 1 D 1 2 0 000000 0000
E0823001 0 1 0 0 0 1 3 4 1 0 0 000000 0000
E0545716 0 1 0 0 0 1 5 2 1 1 0 000000 0000
E3500005 0 1 0 0 0 1 0 A 0 2 0 000000 0000
E11801A9 0 1 0 0 0 1 0 8 0 0 0 000000 0000
E38BA4FF 0 1 0 0 0 1 A C 1 2 0 000000 0000
EA000010 0 1 0 1 0 0 0 0 0 0 0 000010 0000
0BFFFFFE 0 0 0 1 0 0 0 0 0 0 1 FFFFFE 0000
E8B0008A 0 1 0 0 1 0 0 0 0 0 0 000000 008A
E92D40F0 0 1 0 0 1 0 0 0 0 0 0 000000 40F0
E882FFFF 0 1 0 0 1 0 0 0 0 0 0 000000 FFFF
1890000C 4 0 0 0 1 0 0 0 0 0 0 000000 000C
E5954008 0 1 0 0 1 0 4 0 0 0 0 000000 0000
E4476003 0 1 0 0 1 0 6 0 0 0 0 000000 0000
EE012003 0 0 1 0 0 0 0 0 0 0 0 000000 0000
E0010392 0 0 1 0 0 1 0 0 1 1 0 000000 0000
E8900000 0 0 1 0 1 0 0 0 0 0 0 000000 0000
E10F0000 0 0 1 0 0 1 0 8 0 0 0 000000 0000
E7954002 0 0 1 0 1 0 4 0 0 0 0 000000 0000
FFFFFFFF

// ==== src/core_decode_stage.sv ====
`timescale 1ns/1ps

module core_decode_stage
	import core_pkg::*;
(
	input  logic     clk,
	input  logic     reset,

	input  word      insn,
	input  psr_flags flags,
	input  logic     insn_valid,
	output logic     insn_ready,

	output micro_op  uop,
	output logic     uop_valid,
	input  logic     uop_ready
);

	insn_decode dec;
	reg_list list;
	logic load, step, is_last;
	reg_num cur_reg;
	list_index cur_index;

	core_decode decode
	(
		.insn(insn),
		.flags(flags),
		.dec(dec)
	);

	core_issue_seq seq
	(
		.*
	);

	core_reglist_counter walker
	(
		.*
	);

endmodule

// ==== src/core_issue_seq.sv ====
`timescale 1ns/1ps

module core_issue_seq
	import core_pkg::*;
(
	input  logic       clk,
	input  logic       reset,

	input  logic       insn_valid,
	output logic       insn_ready,
	input  insn_decode dec,

	output micro_op    uop,
	output logic       uop_valid,
	input  logic       uop_ready,

	output reg_list    list,
	output logic       load,
	output logic       step,
	input  reg_num     cur_reg,
	input  list_index  cur_index,
	input  logic       is_last
);

	issue_state state;
	insn_decode rec;
	logic take, done, go_multi;

	assign uop_valid = state != IDLE;
	assign done = uop_valid && uop_ready && uop.last;
	assign insn_ready = state == IDLE || done;
	assign take = insn_valid && insn_ready;

	// Execute is already low for undefined words, so an empty list never gets here.
	assign go_multi = dec.ctrl.execute && dec.ctrl.ldst && dec.ldst.multiple;

	assign list = dec.ldst.regs;
	assign load = take;
	assign step = state == MULTI && uop_ready;

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else if (take)
			state <= go_multi ? MULTI : ISSUE;
		else if (done)
			state <= IDLE;
	end

	always_ff @(posedge clk)
		if (take)
			rec <= dec;

	always_comb begin
		uop.dec = rec;
		uop.xfer_reg = rec.ldst.rd;
		uop.xfer_index = '0;
		uop.first = 1'b1;
		uop.last = 1'b1;
		if (state == MULTI) begin
			uop.xfer_reg = cur_reg;
			uop.xfer_index = cur_index;
			uop.first = cur_index == '0;
			uop.last = is_last;
		end
	end

endmodule

// ==== src/core_reglist_counter.sv ====
`timescale 1ns/1ps

module core_reglist_counter
	import core_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	input  reg_list   list,
	input  logic      load,
	input  logic      step,

	output reg_num    cur_reg,
	output list_index cur_index,
	output logic      is_last
);

	reg_list remaining;
	list_index index;

	// Lowest set bit wins.
	always_comb begin
		cur_reg = '0;
		for (int i = 15; i >= 0; i--)
			if (remaining[i])
				cur_reg = reg_num'(i);
	end

	assign cur_index = index;
	assign is_last = (remaining & (remaining - 16'd1)) == '0; // At most one bit left.

	always_ff @(posedge clk) begin
		if (reset) begin
			remaining <= '0;
			index <= '0;
		end else if (load) begin
			remaining <= list;
			index <= '0;
		end else if (step) begin
			remaining <= remaining & (remaining - 16'd1);
			index <= index + 4'd1;
		end
	end

endmodule
